//--- Bender.yml
package:
  name: pentevo_io

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/pentevo_pkg.sv
      - src/zbus_if.sv
      - src/clock_phases.sv
      - src/zsignals.sv
      - src/zports.sv
      - src/sound.sv
      - src/pentevo_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/top_assertions.sv
      - tests/tb_top.sv

//--- src/clock_phases.sv
`timescale 1ns/1ps
`default_nettype none

module clock_phases (
	input  logic fclk,
	input  logic reset,
	output logic f0,
	output logic f1,
	output logic c0,
	output logic c1,
	output logic c2,
	output logic c3
);

	logic [1:0] phase;

	always_ff @(posedge fclk) begin
		if (reset) begin
			phase <= 2'd0;
		end else begin
			phase <= phase + 2'd1;
		end
	end

	// half rate strobes
	assign f0 = ~phase[0];
	assign f1 = phase[0];

	// quarter phases, one hot
	assign c0 = (phase == 2'd0);
	assign c1 = (phase == 2'd1);
	assign c2 = (phase == 2'd2);
	assign c3 = (phase == 2'd3);

endmodule

`default_nettype wire

//--- src/pentevo_consts.svh
`ifndef PENTEVO_CONSTS_SVH
`define PENTEVO_CONSTS_SVH

// z80 bus widths
`define PV_DW 8
`define PV_AW 16

// depth of the z80 strobe synchronizer
`define PV_SYNC_DEPTH 2

// ula rule, any even address hits #fe
`define PV_PORT_FE_MASK 16'h0001
`define PV_PORT_FE_VAL 16'h0000

// covox decodes the low byte only
`define PV_PORT_COVOX 8'hFB

// full decode
`define PV_PORT_SYSCONF 16'h20AF

// 8-bit accumulator plus carry
`define PV_COVOX_ACC_W 9

`endif

//--- src/pentevo_pkg.sv
`default_nettype none

package pentevo_pkg;

	// i/o port hit by the current address
	typedef enum logic [1:0] {
		PORT_NONE,
		PORT_FE,
		PORT_COVOX,
		PORT_SYSCONF
	} port_sel_e;

	// what currently drives the beep pin
	typedef enum logic [1:0] {
		SND_BEEPER,
		SND_TAPE,
		SND_COVOX
	} snd_src_e;

endpackage

`default_nettype wire

//--- src/pentevo_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "pentevo_consts.svh"

module pentevo_top (
	input  logic              fclk,
	input  logic              reset,
	input  logic              iorq_n,
	input  logic              rd_n,
	input  logic              wr_n,
	input  logic              m1_n,
	input  logic [`PV_AW-1:0] a,
	input  logic [`PV_DW-1:0] d_in,
	input  logic              tape_in,
	output logic [`PV_DW-1:0] d_out,
	output logic              d_ena,
	output logic              iorq1_n,
	output logic [2:0]        border,
	output logic [1:0]        turbo,
	output logic              beep
);

	logic              f0;
	logic              c0;
	logic              c1;
	logic              c2;
	logic              c3;
	logic              beeper_mux;
	logic              beeper_wr;
	logic              covox_wr;
	logic [`PV_DW-1:0] wr_data;

	zbus_if zbus_i ();

	////////////////////
	// clocking
	////////////////////

	clock_phases clock_phases_i (
		.fclk  (fclk),
		.reset (reset),
		.f0    (f0),
		.f1    (),
		.c0    (c0),
		.c1    (c1),
		.c2    (c2),
		.c3    (c3)
	);

	////////////////////
	// z80 i/o side
	////////////////////

	zsignals zsignals_i (
		.fclk   (fclk),
		.reset  (reset),
		.iorq_n (iorq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.m1_n   (m1_n),
		.bus    (zbus_i.src)
	);

	zports zports_i (
		.fclk       (fclk),
		.reset      (reset),
		.a          (a),
		.d_in       (d_in),
		.tape_in    (tape_in),
		.bus        (zbus_i.dst),
		.d_out      (d_out),
		.d_ena      (d_ena),
		.iorq1_n    (iorq1_n),
		.border     (border),
		.turbo      (turbo),
		.beeper_mux (beeper_mux),
		.beeper_wr  (beeper_wr),
		.covox_wr   (covox_wr),
		.wr_data    (wr_data)
	);

	// beeper, tapeout and covox onto one pin
	sound sound_i (
		.fclk       (fclk),
		.reset      (reset),
		.f0         (f0),
		.d_in       (wr_data),
		.beeper_wr  (beeper_wr),
		.covox_wr   (covox_wr),
		.beeper_mux (beeper_mux),
		.beep       (beep)
	);

endmodule

`default_nettype wire

//--- src/sound.sv
`timescale 1ns/1ps
`default_nettype none

`include "pentevo_consts.svh"

module sound (
	input  logic              fclk,
	input  logic              reset,
	input  logic              f0,
	input  logic [`PV_DW-1:0] d_in,
	input  logic              beeper_wr,
	input  logic              covox_wr,
	input  logic              beeper_mux,
	output logic              beep
);

	import pentevo_pkg::*;

	logic                       beeper_bit;
	logic                       tape_bit;
	logic                       covox_on;
	logic [`PV_DW-1:0]          covox;
	logic [`PV_DW-1:0]          acc;
	logic [`PV_COVOX_ACC_W-1:0] sum;
	snd_src_e                   src;

	////////////////////
	// source registers
	////////////////////

	always_ff @(posedge fclk) begin
		if (reset) begin
			beeper_bit <= 1'b0;
			tape_bit   <= 1'b0;
			covox      <= '0;
			covox_on   <= 1'b0;
		end else if (beeper_wr) begin
			beeper_bit <= d_in[4];
			tape_bit   <= d_in[3];
			covox_on   <= 1'b0;
		end else if (covox_wr) begin
			covox    <= d_in;
			covox_on <= 1'b1;
		end
	end

	always_comb begin
		if (covox_on) begin
			src = SND_COVOX;
		end else if (beeper_mux) begin
			src = SND_TAPE;
		end else begin
			src = SND_BEEPER;
		end
	end

	////////////////////
	// delta-sigma dac
	////////////////////

	assign sum = {1'b0, acc} + {1'b0, covox};

	always_ff @(posedge fclk) begin
		if (reset) begin
			acc  <= '0;
			beep <= 1'b0;
		end else begin
			if (f0 && covox_on) begin
				acc <= sum[`PV_DW-1:0];
			end
			// carry lasts one fclk, so ones per 256 f0 equal the byte
			case (src)
				SND_COVOX: beep <= f0 & sum[`PV_COVOX_ACC_W-1];
				SND_TAPE:  beep <= tape_bit;
				default:   beep <= beeper_bit;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/zbus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface zbus_if;

	// levels, valid while the z80 holds the strobes
	logic iorq;
	logic iord;
	logic iowr;

	// single fclk pulses at the start of a cycle
	logic iord_s;
	logic iowr_s;

	modport src (
		output iorq, iord, iowr, iord_s, iowr_s
	);

	modport dst (
		input iorq, iord, iowr, iord_s, iowr_s
	);

endinterface

`default_nettype wire

//--- src/zports.sv
`timescale 1ns/1ps
`default_nettype none

`include "pentevo_consts.svh"

module zports (
	input  logic              fclk,
	input  logic              reset,
	input  logic [`PV_AW-1:0] a,
	input  logic [`PV_DW-1:0] d_in,
	input  logic              tape_in,
	zbus_if.dst               bus,
	output logic [`PV_DW-1:0] d_out,
	output logic              d_ena,
	output logic              iorq1_n,
	output logic [2:0]        border,
	output logic [1:0]        turbo,
	output logic              beeper_mux,
	output logic              beeper_wr,
	output logic              covox_wr,
	output logic [`PV_DW-1:0] wr_data
);

	import pentevo_pkg::*;

	port_sel_e         sel;
	logic [`PV_DW-1:0] sysconf;
	logic [`PV_DW-1:0] rd_live;
	logic [`PV_DW-1:0] rd_hold;
	logic [1:0]        tape_sync;
	logic              read_hit;

	////////////////////
	// address decode
	////////////////////

	always_comb begin
		if ((a & `PV_PORT_FE_MASK) == `PV_PORT_FE_VAL) begin
			sel = PORT_FE;
		end else if (a == `PV_PORT_SYSCONF) begin
			sel = PORT_SYSCONF;
		end else if (a[7:0] == `PV_PORT_COVOX) begin
			sel = PORT_COVOX;
		end else begin
			sel = PORT_NONE;
		end
	end

	// nobody inside claims the port, hand it to the bus
	assign iorq1_n = ~(bus.iorq && sel == PORT_NONE);

	////////////////////
	// writes
	////////////////////

	always_ff @(posedge fclk) begin
		if (reset) begin
			border    <= 3'd0;
			sysconf   <= '0;
			beeper_wr <= 1'b0;
			covox_wr  <= 1'b0;
		end else begin
			beeper_wr <= bus.iowr_s && sel == PORT_FE;
			covox_wr  <= bus.iowr_s && sel == PORT_COVOX;
			if (bus.iowr_s && sel == PORT_FE) begin
				border <= d_in[2:0];
			end
			if (bus.iowr_s && sel == PORT_SYSCONF) begin
				sysconf <= d_in;
			end
		end
	end

	// data for the sound strobes, stable for the whole write
	always_ff @(posedge fclk) begin
		if (bus.iowr) begin
			wr_data <= d_in;
		end
	end

	assign turbo      = sysconf[1:0];
	assign beeper_mux = sysconf[2];

	////////////////////
	// reads
	////////////////////

	always_ff @(posedge fclk) begin
		if (reset) begin
			tape_sync <= 2'b00;
		end else begin
			tape_sync <= {tape_sync[0], tape_in};
		end
	end

	always_comb begin
		case (sel)
			PORT_FE: rd_live = {1'b1, tape_sync[1], 6'b111111};
			default: rd_live = sysconf;
		endcase
	end

	// freeze read data for the rest of the cycle
	always_ff @(posedge fclk) begin
		if (bus.iord_s) begin
			rd_hold <= rd_live;
		end
	end

	assign read_hit = (sel == PORT_FE) || (sel == PORT_SYSCONF);
	assign d_out    = bus.iord_s ? rd_live : rd_hold;
	assign d_ena    = bus.iord && read_hit;

endmodule

`default_nettype wire

//--- src/zsignals.sv
`timescale 1ns/1ps
`default_nettype none

`include "pentevo_consts.svh"

module zsignals (
	input  logic fclk,
	input  logic reset,
	input  logic iorq_n,
	input  logic rd_n,
	input  logic wr_n,
	input  logic m1_n,
	zbus_if.src  bus
);

	// bit order: iorq_n, rd_n, wr_n, m1_n
	logic [3:0] sync [`PV_SYNC_DEPTH];
	logic [3:0] stb_n;
	logic       iorq_nx;
	logic       iord_nx;
	logic       iowr_nx;

	// strobes idle high
	always_ff @(posedge fclk) begin
		if (reset) begin
			for (int i = 0; i < `PV_SYNC_DEPTH; i++) begin
				sync[i] <= 4'b1111;
			end
		end else begin
			sync[0] <= {iorq_n, rd_n, wr_n, m1_n};
			for (int i = 1; i < `PV_SYNC_DEPTH; i++) begin
				sync[i] <= sync[i-1];
			end
		end
	end

	assign stb_n = sync[`PV_SYNC_DEPTH-1];

	// int ack has m1 low, keep it out of the port logic
	assign iorq_nx = ~stb_n[3] & stb_n[0];
	assign iord_nx = iorq_nx & ~stb_n[2];
	assign iowr_nx = iorq_nx & ~stb_n[1];

	always_ff @(posedge fclk) begin
		if (reset) begin
			bus.iorq   <= 1'b0;
			bus.iord   <= 1'b0;
			bus.iowr   <= 1'b0;
			bus.iord_s <= 1'b0;
			bus.iowr_s <= 1'b0;
		end else begin
			bus.iorq   <= iorq_nx;
			bus.iord   <= iord_nx;
			bus.iowr   <= iowr_nx;
			// rising edge against the previous level
			bus.iord_s <= iord_nx & ~bus.iord;
			bus.iowr_s <= iowr_nx & ~bus.iowr;
		end
	end

endmodule

`default_nettype wire

//--- tests/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "pentevo_consts.svh"

module tb_top;

	logic              fclk;
	logic              reset;
	logic              iorq_n;
	logic              rd_n;
	logic              wr_n;
	logic              m1_n;
	logic [`PV_AW-1:0] a;
	logic [`PV_DW-1:0] d_in;
	logic              tape_in;
	logic [`PV_DW-1:0] d_out;
	logic              d_ena;
	logic              iorq1_n;
	logic [2:0]        border;
	logic [1:0]        turbo;
	logic              beep;

	int                checks;
	int                errors;
	logic              iorq1_seen;
	logic              ena_seen;
	logic [`PV_DW-1:0] rd_data;
	logic [31:0]       lfsr;

	pentevo_top dut_i (
		.fclk    (fclk),
		.reset   (reset),
		.iorq_n  (iorq_n),
		.rd_n    (rd_n),
		.wr_n    (wr_n),
		.m1_n    (m1_n),
		.a       (a),
		.d_in    (d_in),
		.tape_in (tape_in),
		.d_out   (d_out),
		.d_ena   (d_ena),
		.iorq1_n (iorq1_n),
		.border  (border),
		.turbo   (turbo),
		.beep    (beep)
	);

	initial begin
		fclk = 1'b0;
		forever #10 fclk = ~fclk;
	end

	// watchdog
	initial begin
		repeat (40000) @(posedge fclk);
		$display("simulation timed out before the tests finished");
		$display("TESTS FAILED");
		$finish;
	end

	////////////////////
	// helpers
	////////////////////

	task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond === 1'b1) else begin
			errors++;
			$display("at %0t ns: %s", $time, what);
		end
	endtask

	// 32-bit galois lfsr
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 32'h80200003;
		end
		return n;
	endfunction

	task automatic random_byte(output logic [7:0] b);
		int i;
		b = '0;
		for (i = 0; i < 8; i++) begin
			b = {b[6:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// one z80 i/o cycle, strobes held for 8 fclk
	task automatic io_cycle(input logic [15:0] addr, input logic [7:0] data,
			input logic m1, input logic is_read);
		int i;
		int n;
		@(posedge fclk);
		a    <= addr;
		d_in <= data;
		@(posedge fclk);
		iorq_n <= 1'b0;
		m1_n   <= m1;
		rd_n   <= ~is_read;
		wr_n   <= is_read;
		iorq1_seen = 1'b0;
		ena_seen   = 1'b0;
		for (i = 0; i < 8; i++) begin
			@(negedge fclk);
			iorq1_seen = iorq1_seen | ~iorq1_n;
			ena_seen   = ena_seen | d_ena;
			rd_data    = d_out;
			@(posedge fclk);
		end
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
		m1_n   <= 1'b1;
		// d_ena drops once the synchronizer sees the release
		n = 0;
		@(negedge fclk);
		while (d_ena && n < 8) begin
			@(negedge fclk);
			n++;
		end
		check_true(!d_ena, "d_ena stayed high after the cycle ended");
		repeat (4) @(negedge fclk);
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data, input logic m1);
		io_cycle(addr, data, m1, 1'b0);
	endtask

	task automatic io_read(input logic [15:0] addr, input logic m1);
		io_cycle(addr, 8'h00, m1, 1'b1);
	endtask

	task automatic wait_beep(input logic exp);
		int n;
		n = 0;
		while (beep !== exp && n < 32) begin
			@(negedge fclk);
			n++;
		end
		check_val("beep", beep, exp);
	endtask

	task automatic count_beep(input int cycles, output int highs);
		int i;
		highs = 0;
		for (i = 0; i < cycles; i++) begin
			@(negedge fclk);
			if (beep) highs++;
		end
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic test_reset_state();
		int highs;
		check_val("d_ena", d_ena, 1'b0);
		check_val("iorq1_n", iorq1_n, 1'b1);
		check_val("border", border, 3'd0);
		check_val("turbo", turbo, 2'd0);
		count_beep(64, highs);
		check_val("beep highs after reset", highs, 0);
	endtask

	task automatic test_fe_port();
		logic [7:0] exp;
		int t;
		io_write(16'h00FE, 8'h05, 1'b1);
		check_val("border", border, 3'd5);
		io_write(16'h7FFE, 8'h03, 1'b1);
		check_val("border", border, 3'd3);
		for (t = 0; t < 2; t++) begin
			@(posedge fclk);
			tape_in <= t[0];
			// all ones but the tape bit
			exp = 8'hFF;
			exp[6] = t[0];
			io_read(16'h00FE, 1'b1);
			check_true(ena_seen, "d_ena never rose on a read of port FE");
			check_val("d_out", rd_data, exp);
			io_read(16'h1234, 1'b1);
			check_val("d_out", rd_data, exp);
			io_read(16'hFFFE, 1'b1);
			check_val("d_out", rd_data, exp);
		end
	endtask

	task automatic test_sysconf();
		io_write(16'h20AF, 8'h02, 1'b1);
		check_val("turbo", turbo, 2'd2);
		io_read(16'h20AF, 1'b1);
		check_true(ena_seen, "d_ena never rose on a read of port 20AF");
		check_val("d_out", rd_data, 8'h02);
		// near miss goes out on iorq1_n
		io_write(16'h21AF, 8'h01, 1'b1);
		check_true(iorq1_seen, "iorq1_n stayed high for a write to port 21AF");
		check_val("turbo", turbo, 2'd2);
		check_val("border", border, 3'd3);
		io_read(16'h20AF, 1'b1);
		check_val("d_out", rd_data, 8'h02);
	endtask

	task automatic test_beeper();
		io_write(16'h00FE, 8'h10, 1'b1);
		wait_beep(1'b1);
		// mux set, tape-out bit drives beep
		io_write(16'h20AF, 8'h04, 1'b1);
		check_val("turbo", turbo, 2'd0);
		wait_beep(1'b0);
		io_write(16'h00FE, 8'h08, 1'b1);
		wait_beep(1'b1);
		io_write(16'h00FE, 8'h10, 1'b1);
		wait_beep(1'b0);
	endtask

	task automatic test_covox();
		logic [7:0] hi;
		logic [7:0] val;
		int highs;
		int k;
		io_write(16'h20AF, 8'h00, 1'b1);
		for (k = 0; k < 5; k++) begin
			random_byte(hi);
			random_byte(val);
			io_write({hi, 8'hFB}, val, 1'b1);
			repeat (16) @(negedge fclk);
			// 512 fclk is 256 f0 pulses
			count_beep(512, highs);
			check_val("beep highs per 256 f0", highs, val);
		end
		io_write(16'h00FE, 8'h10, 1'b1);
		wait_beep(1'b1);
		count_beep(32, highs);
		check_val("beep highs after port FE write", highs, 32);
	endtask

	task automatic test_int_ack();
		int highs;
		io_write(16'h00FE, 8'h02, 1'b1);
		io_write(16'h20AF, 8'h01, 1'b1);
		io_write(16'h00FE, 8'h15, 1'b0);
		io_write(16'h20AF, 8'h06, 1'b0);
		io_write(16'h00FB, 8'h80, 1'b0);
		io_write(16'h21AF, 8'hFF, 1'b0);
		check_true(!iorq1_seen, "iorq1_n went low during an interrupt acknowledge");
		check_val("border", border, 3'd2);
		check_val("turbo", turbo, 2'd1);
		io_read(16'h20AF, 1'b0);
		check_true(!ena_seen, "d_ena rose during an interrupt acknowledge");
		count_beep(64, highs);
		check_val("beep highs after int ack writes", highs, 0);
	endtask

	initial begin
		reset   = 1'b1;
		iorq_n  = 1'b1;
		rd_n    = 1'b1;
		wr_n    = 1'b1;
		m1_n    = 1'b1;
		a       = '0;
		d_in    = '0;
		tape_in = 1'b0;
		checks  = 0;
		errors  = 0;
		lfsr    = 32'd92339;
		repeat (8) @(posedge fclk);
		reset <= 1'b0;
		@(negedge fclk);
		test_reset_state();
		test_fe_port();
		test_sysconf();
		test_beeper();
		test_covox();
		test_int_ack();
		$display("checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, dut_i.assertions_i.fail_count);
		if (errors == 0 && dut_i.assertions_i.fail_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/top_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module top_assertions (
	input logic fclk,
	input logic reset,
	input logic iorq_n,
	input logic m1_n,
	input logic d_ena,
	input logic iorq1_n,
	input logic f0,
	input logic c0,
	input logic c1,
	input logic c2,
	input logic c3
);

	int fail_count;

	initial begin
		fail_count = 0;
	end

	// three fclk of synchronizer before d_ena follows iorq_n
	ena_idle_a: assert property (@(posedge fclk) disable iff (reset)
		iorq_n && $past(iorq_n, 1) && $past(iorq_n, 2) && $past(iorq_n, 3) |-> !d_ena)
	else begin
		fail_count++;
		$error("d_ena high with iorq_n released");
	end

	// external ports only get synchronized requests outside int ack
	ena_ext_a: assert property (@(posedge fclk) disable iff (reset)
		!iorq1_n |-> !d_ena && !$past(iorq_n, 3) && $past(m1_n, 3))
	else begin
		fail_count++;
		$error("iorq1_n low together with d_ena or without a valid request");
	end

	// quarter phases step c0 to c3 in turn
	phase_a: assert property (@(posedge fclk) disable iff (reset)
		$onehot({c0, c1, c2, c3}) &&
		($past(reset) || {c0, c1, c2, c3} == $past({c3, c0, c1, c2})))
	else begin
		fail_count++;
		$error("quarter phases not one hot or out of order");
	end

	// first cycle out of reset repeats f0
	f0_a: assert property (@(posedge fclk) disable iff (reset)
		!$past(reset) |-> f0 != $past(f0))
	else begin
		fail_count++;
		$error("f0 did not alternate");
	end

endmodule

bind pentevo_top top_assertions assertions_i (
	.fclk    (fclk),
	.reset   (reset),
	.iorq_n  (iorq_n),
	.m1_n    (m1_n),
	.d_ena   (d_ena),
	.iorq1_n (iorq1_n),
	.f0      (f0),
	.c0      (c0),
	.c1      (c1),
	.c2      (c2),
	.c3      (c3)
);

`default_nettype wire

//--- verilog.f
+incdir+src
src/pentevo_pkg.sv
src/zbus_if.sv
src/clock_phases.sv
src/zsignals.sv
src/zports.sv
src/sound.sv
src/pentevo_top.sv
tests/top_assertions.sv
tests/tb_top.sv
